// ==== compile.f ====
common/etx_pkg.sv
common/etx_protocol_if.sv
etx_protocol/etx_protocol.sv
rtl/etx_serializer.sv
rtl/etx_top.sv
testbench/etx_checker.sv
testbench/etx_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the etx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module etx_tb -f compile.f \
   --Mdir obj_dir -o etx_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/etx_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "^=== PASS ===$"; then
   exit 0
fi
exit 1

// ==== testbench/etx_tb.sv ====
`timescale 1ns/1ps

module etx_tb;

   import etx_pkg::*;

   localparam logic [11:0] NODE_ID    = 12'h810;
   localparam int          NUM_PKTS   = 400;
   localparam int          MAX_CYCLES = NUM_PKTS * 6 + 200;

   logic                clk;
   logic                nreset;
   logic                etx_access;
   logic [PW-1:0]       etx_packet;
   logic                etx_rd_wait;
   logic                etx_wr_wait;
   logic                tx_enable;
   logic                tx_rd_wait;
   logic                tx_wr_wait;
   logic [LINK_W-1:0]   link_data;
   logic                link_valid;
   logic                link_start;
   int                  mismatch_count;
   int                  extra_count;
   int                  pending_count;
   int                  sent;
   int                  cycle_count;
   logic [31:0]         lcg_state;
   logic [15:0]         rnd;
   logic                toggle_mode;   // Random enable and remote waits

   etx_top #(.ID(NODE_ID)) dut_i (.*);

   etx_checker #(.ID(NODE_ID)) checker_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function logic [15:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   // Type bits of r are write 6, datamode 5:4 and ctrlmode 3:0
   function logic [PW-1:0] make_packet(input logic [31:0] dst, input logic [15:0] r);
      return {1'b0, next_rand(), next_rand(), next_rand(), next_rand(), dst,
              r[3:0], r[5:4], r[6]};
   endfunction

   task automatic drive_controls();
      tx_enable  = !toggle_mode || (next_rand() % 8 != 0);
      tx_wr_wait = toggle_mode && (next_rand() % 4 == 0);
      tx_rd_wait = toggle_mode && (next_rand() % 4 == 0);
   endtask

   task automatic idle_cycles(input int n);
      etx_access = 1'b0;
      repeat (n)
      begin
         @(negedge clk);
         drive_controls();
      end
   endtask

   // Held until the wait for its type drops
   task automatic send_packet(input logic [PW-1:0] pkt);
      logic taken;
      etx_packet = pkt;
      etx_access = 1'b1;
      taken      = 1'b0;
      while (!taken)
      begin
         @(posedge clk);
         taken = tx_enable && !(pkt[0] ? etx_wr_wait : etx_rd_wait);
         @(negedge clk);
         drive_controls();
      end
      sent++;
   endtask

   task automatic double_write_run();
      logic [31:0] addr;
      addr = {next_rand(), next_rand()} & 32'hFFFF_FFF8;
      rnd  = next_rand() | 16'h0070;
      repeat (2 + next_rand() % 7)
      begin
         send_packet(make_packet(addr, rnd));
         addr = addr + ((next_rand() % 10 == 0) ? 32'd16 : 32'd8);   // Address break now and then
         if (next_rand() % 10 == 0)
            rnd[3:0] = rnd[3:0] + 4'd1;   // Type break
         if (next_rand() % 8 == 0)
            idle_cycles(1);
      end
   endtask

   task automatic finish_run(input logic timed_out);
      if (pending_count != 0)
         $display("%0d expected link beats never appeared", pending_count);
      $display("Errors: %0d mismatches, %0d unexpected beats, %0d missing beats, %0d timeouts",
               mismatch_count, extra_count, pending_count, timed_out);
      if (!timed_out && mismatch_count + extra_count + pending_count == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   endtask

   //##########################################################################
   // Stimulus phases
   //##########################################################################
   initial
   begin
      lcg_state   = 32'd57;
      toggle_mode = 1'b0;
      sent        = 0;
      nreset      = 1'b0;
      etx_access  = 1'b0;
      etx_packet  = '0;
      tx_enable   = 1'b0;
      tx_rd_wait  = 1'b0;
      tx_wr_wait  = 1'b0;
      repeat (5) @(negedge clk);
      nreset = 1'b1;
      idle_cycles(2);
      while (sent < 120)
      begin
         send_packet(make_packet({next_rand(), next_rand()}, next_rand()));
         if (next_rand() % 4 == 0)
            idle_cycles(1);
      end
      while (sent < 240)
         double_write_run();
      // Own ID mix with half in the read response group
      while (sent < 320)
      begin
         rnd = next_rand();
         send_packet(make_packet({rnd[8] ? NODE_ID : rnd[15:4],
                                  rnd[7] ? EGROUP_RR : rnd[15:12], next_rand()}, rnd));
      end
      toggle_mode = 1'b1;
      while (sent < NUM_PKTS)
         send_packet(make_packet({next_rand(), next_rand()}, next_rand()));
      toggle_mode = 1'b0;
      idle_cycles(1);
      while (pending_count != 0)
         @(negedge clk);
      idle_cycles(4);   // Room for a stray beat
      finish_run(1'b0);
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      finish_run(1'b1);
   end

endmodule

// ==== testbench/etx_checker.sv ====
`timescale 1ns/1ps

module etx_checker
   #(parameter logic [11:0] ID = 12'h810)
   (
   input  logic                          clk,
   input  logic                          nreset,
   input  logic                          etx_access,
   input  logic [etx_pkg::PW-1:0]        etx_packet,
   input  logic                          etx_rd_wait,
   input  logic                          etx_wr_wait,
   input  logic                          tx_enable,
   input  logic                          tx_rd_wait,
   input  logic                          tx_wr_wait,
   input  logic [etx_pkg::LINK_W-1:0]    link_data,
   input  logic                          link_valid,
   input  logic                          link_start,
   output int                            mismatch_count,
   output int                            extra_count,
   output int                            pending_count
   );

   import etx_pkg::*;

   logic [LINK_W:0]   exp_q[$];     // {start, beat}
   logic [LINK_W:0]   exp_beat;
   emesh_fields_t     f;
   emesh_fields_t     prev_f;
   logic              prev_sent;    // Sent packet accepted on the last edge
   logic              accept;
   logic              sent;
   logic              burst;
   logic [1:0]        rd_s;         // Remote wait synchronizer model
   logic [1:0]        wr_s;
   logic              m_access;     // Held packet on the interface
   logic              m_burst;
   logic              m_header;     // Serializer sending a header
   logic              m_io_wait;
   logic              exp_rd_wait;
   logic              exp_wr_wait;
   logic              next_header;
   logic              next_io_wait;

   always @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         exp_q.delete();
         prev_sent      = 1'b0;
         rd_s           = 2'b00;
         wr_s           = 2'b00;
         m_access       = 1'b0;
         m_burst        = 1'b0;
         m_header       = 1'b0;
         m_io_wait      = 1'b0;
         mismatch_count = 0;
         extra_count    = 0;
         pending_count  = 0;
      end
      else
      begin
         //##########################################################################
         // Link beats against the queue head
         //##########################################################################
         if (link_valid && exp_q.size() == 0)
         begin
            extra_count++;
            $display("MISMATCH at %0t: link beat %h with no packet pending", $time, link_data);
         end
         else if (link_valid)
         begin
            exp_beat = exp_q.pop_front();
            if ({link_start, link_data} !== exp_beat)
            begin
               mismatch_count++;
               $display("MISMATCH at %0t: beat %h start %b, expected %h start %b", $time,
                        link_data, link_start, exp_beat[LINK_W-1:0], exp_beat[LINK_W]);
            end
         end

         // Push-back toward the master
         exp_rd_wait = rd_s[1] | m_io_wait;
         exp_wr_wait = wr_s[1] | m_io_wait;
         if (etx_rd_wait !== exp_rd_wait || etx_wr_wait !== exp_wr_wait)
         begin
            mismatch_count++;
            $display("MISMATCH at %0t: waits rd %b wr %b, expected rd %b wr %b", $time,
                     etx_rd_wait, etx_wr_wait, exp_rd_wait, exp_wr_wait);
         end

         //##########################################################################
         // System side acceptance model
         //##########################################################################
         f      = emesh_fields_t'(etx_packet);
         accept = etx_access && tx_enable && !(f.write ? exp_wr_wait : exp_rd_wait);
         sent   = accept && !((f.dstaddr[31:20] == ID) && (f.dstaddr[19:16] != EGROUP_RR));
         burst  = prev_sent && f.write && (f.datamode == DM_DOUBLE) && prev_f.write &&
                  (prev_f.datamode == DM_DOUBLE) && (f.ctrlmode == prev_f.ctrlmode) &&
                  (f.dstaddr == prev_f.dstaddr + 32'd8);
         if (sent && !burst)
            exp_q.push_back({1'b1, f.write, f.datamode, f.ctrlmode, 25'd0, f.dstaddr});
         if (sent)
            exp_q.push_back({1'b0, f.srcaddr, f.data});   // Data beat always follows
         prev_sent     = sent;
         prev_f        = f;
         pending_count = exp_q.size();

         // IO handshake with one stall cycle per header
         next_header  = m_access && !m_burst && !m_header;
         next_io_wait = !m_header && (m_io_wait || (m_access && !m_burst));
         if (!m_io_wait)
         begin
            m_access = sent;
            m_burst  = sent && burst;
         end
         m_header  = next_header;
         m_io_wait = next_io_wait;
         rd_s      = {rd_s[0], tx_rd_wait};
         wr_s      = {wr_s[0], tx_wr_wait};
      end
   end

endmodule

// ==== rtl/etx_top.sv ====
`timescale 1ns/1ps

module etx_top
   #(parameter logic [11:0] ID = 12'h810)
   (
   input  logic                          clk,
   input  logic                          nreset,
   // System side
   input  logic                          etx_access,
   input  logic [etx_pkg::PW-1:0]        etx_packet,
   output logic                          etx_rd_wait,
   output logic                          etx_wr_wait,
   // Control and remote push-back
   input  logic                          tx_enable,
   input  logic                          tx_rd_wait,
   input  logic                          tx_wr_wait,
   // Link
   output logic [etx_pkg::LINK_W-1:0]    link_data,
   output logic                          link_valid,
   output logic                          link_start
   );

   etx_protocol_if tx_if ();

   //##########################################################################
   // Filter, hold and push-back
   //##########################################################################
   etx_protocol #(
      .ID          (ID)
   ) protocol_i (
      .clk         (clk),
      .nreset      (nreset),
      .etx_access  (etx_access),
      .etx_packet  (etx_packet),
      .etx_rd_wait (etx_rd_wait),
      .etx_wr_wait (etx_wr_wait),
      .tx_enable   (tx_enable),
      .tx_rd_wait  (tx_rd_wait),
      .tx_wr_wait  (tx_wr_wait),
      .tx          (tx_if.proto)
   );

   // Header and data beats onto the link
   etx_serializer serializer_i (
      .clk         (clk),
      .nreset      (nreset),
      .tx          (tx_if.ser),
      .link_data   (link_data),
      .link_valid  (link_valid),
      .link_start  (link_start)
   );

endmodule

// ==== rtl/etx_serializer.sv ====
`timescale 1ns/1ps

module etx_serializer
   (
   input  logic                          clk,
   input  logic                          nreset,
   etx_protocol_if.ser                   tx,
   output logic [etx_pkg::LINK_W-1:0]    link_data,
   output logic                          link_valid,
   output logic                          link_start
   );

   import etx_pkg::*;

   ser_state_t      state;
   emesh_fields_t   in_f;     // Packet on the interface
   emesh_fields_t   held_f;   // Packet being sent
   logic            take;

   //##########################################################################
   // Beat formatting
   //##########################################################################
   function automatic logic [LINK_W-1:0] header_beat(input emesh_fields_t f);
      header_beat = {f.write, f.datamode, f.ctrlmode, {HDR_PAD_W{1'b0}}, f.dstaddr};
   endfunction

   function automatic logic [LINK_W-1:0] data_beat(input emesh_fields_t f);
      data_beat = {f.srcaddr, f.data};
   endfunction

   assign in_f = emesh_fields_t'(tx.packet);

   // Same edges on which the protocol reloads
   assign take = tx.access && (state != SER_HEADER);

   assign tx.io_ack = (state == SER_HEADER);

   //##########################################################################
   // Beat sequencer
   //##########################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state      <= SER_IDLE;
         link_valid <= 1'b0;
         link_start <= 1'b0;
      end
      else if (take)
      begin
         link_valid <= 1'b1;
         if (tx.burst)
         begin
            state      <= SER_DATA;   // Skip header
            link_start <= 1'b0;
         end
         else
         begin
            state      <= SER_HEADER;
            link_start <= 1'b1;
         end
      end
      else if (state == SER_HEADER)
      begin
         state      <= SER_DATA;
         link_valid <= 1'b1;
         link_start <= 1'b0;
      end
      else
      begin
         state      <= SER_IDLE;
         link_valid <= 1'b0;
         link_start <= 1'b0;
      end
   end

   // Payload side
   always_ff @(posedge clk)
   begin
      if (take)
         held_f <= in_f;
   end

   always_ff @(posedge clk)
   begin
      if (take)
      begin
         if (tx.burst)
            link_data <= data_beat(in_f);
         else
            link_data <= header_beat(in_f);
      end
      else if (state == SER_HEADER)
         link_data <= data_beat(held_f);   // Second beat of normal packet
   end

endmodule

// ==== etx_protocol/etx_protocol.sv ====
`timescale 1ns/1ps

module etx_protocol
   #(parameter logic [11:0] ID = 12'h810)
   (
   input  logic                      clk,
   input  logic                      nreset,
   // System side
   input  logic                      etx_access,
   input  logic [etx_pkg::PW-1:0]    etx_packet,
   output logic                      etx_rd_wait,
   output logic                      etx_wr_wait,
   // Control and remote push-back
   input  logic                      tx_enable,
   input  logic                      tx_rd_wait,    // Async
   input  logic                      tx_wr_wait,    // Async
   // To serializer
   etx_protocol_if.proto             tx
   );

   import etx_pkg::*;

   emesh_fields_t   etx_f;          // Incoming packet
   emesh_fields_t   last_f;         // Held packet
   logic [PW-1:0]   tx_packet;
   logic            tx_access;
   logic            tx_burst;
   logic            tx_fresh;       // Held packet loaded on last edge
   logic            io_wait;
   logic [1:0]      rd_sync;
   logic [1:0]      wr_sync;
   logic            rd_wait_sync;
   logic            wr_wait_sync;
   logic            own_id_drop;
   logic            type_wait;
   logic            etx_valid;
   logic            burst_type_match;
   logic            burst_addr_match;
   logic            burst_in;

   assign etx_f  = emesh_fields_t'(etx_packet);
   assign last_f = emesh_fields_t'(tx_packet);

   //##########################################################################
   // Remote wait synchronizers
   //##########################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rd_sync <= 2'b00;
         wr_sync <= 2'b00;
      end
      else
      begin
         rd_sync <= {rd_sync[0], tx_rd_wait};
         wr_sync <= {wr_sync[0], tx_wr_wait};
      end
   end

   assign rd_wait_sync = rd_sync[1];
   assign wr_wait_sync = wr_sync[1];

   //##########################################################################
   // Filter and burst detection
   //##########################################################################

   // Own register space, read responses excepted
   assign own_id_drop = (etx_f.dstaddr[AW-1:ID_LSB] == ID) &&
                        (etx_f.dstaddr[ID_LSB-1:GRP_LSB] != EGROUP_RR);

   assign type_wait = etx_f.write ? wr_wait_sync : rd_wait_sync;

   assign etx_valid = tx_enable && etx_access && !type_wait && !own_id_drop;

   assign burst_type_match = {last_f.ctrlmode, last_f.datamode, last_f.write} ==
                             {etx_f.ctrlmode, etx_f.datamode, etx_f.write};

   assign burst_addr_match = (last_f.dstaddr + BURST_STRIDE) == etx_f.dstaddr;

   // Only against a packet accepted on the previous edge
   assign burst_in = tx_access && tx_fresh &&
                     etx_f.write && (etx_f.datamode == DM_DOUBLE) &&
                     burst_type_match && burst_addr_match;

   //##########################################################################
   // Transmit hold register
   //##########################################################################

   // One cycle stall per header, released by io_ack
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         io_wait <= 1'b0;
      else if (tx.io_ack)
         io_wait <= 1'b0;
      else if (tx_access && !tx_burst)
         io_wait <= 1'b1;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         tx_access <= 1'b0;
         tx_burst  <= 1'b0;
         tx_fresh  <= 1'b0;
      end
      else
      begin
         tx_fresh <= !io_wait;
         if (!io_wait)
         begin
            tx_access <= etx_valid;
            tx_burst  <= etx_valid && burst_in;   // Loads with its packet
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!io_wait)
         tx_packet <= etx_packet;
   end

   assign tx.packet = tx_packet;
   assign tx.access = tx_access;
   assign tx.burst  = tx_burst;

   // Push-back toward the master
   assign etx_rd_wait = rd_wait_sync | io_wait;
   assign etx_wr_wait = wr_wait_sync | io_wait;

endmodule

// ==== common/etx_protocol_if.sv ====
`timescale 1ns/1ps

// Held packet from protocol to serializer
interface etx_protocol_if;

   import etx_pkg::*;

   logic [PW-1:0]   packet;
   logic            access;
   logic            burst;    // Continuation, data beat only
   logic            io_ack;   // Serializer busy with header

   modport proto (
      output packet,
      output access,
      output burst,
      input  io_ack
   );

   modport ser (
      input  packet,
      input  access,
      input  burst,
      output io_ack
   );

endinterface

// ==== common/etx_pkg.sv ====
package etx_pkg;

   //##########################################################################
   // Widths
   //##########################################################################
   localparam int PW     = 104;   // Mesh packet
   localparam int AW     = 32;
   localparam int DW     = 32;
   localparam int LINK_W = 64;    // One link beat

   // Destination address split into node ID and group
   localparam int ID_LSB  = 20;
   localparam int GRP_LSB = 16;

   // Read response group, passes the own-ID filter
   localparam logic [3:0] EGROUP_RR = 4'hE;

   // Address step between two double writes of a burst
   localparam logic [AW-1:0] BURST_STRIDE = 32'h8;

   // Zero fill of the header beat between ctrlmode and dstaddr
   localparam int HDR_PAD_W = LINK_W - 7 - AW;

   //##########################################################################
   // Types
   //##########################################################################
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,
      DM_HALF   = 2'b01,
      DM_WORD   = 2'b10,
      DM_DOUBLE = 2'b11
   } datamode_t;

   // Packet overlay, MSB first
   typedef struct packed {
      logic            pad;
      logic [AW-1:0]   srcaddr;
      logic [DW-1:0]   data;
      logic [AW-1:0]   dstaddr;
      logic [3:0]      ctrlmode;
      datamode_t       datamode;
      logic            write;
   } emesh_fields_t;

   typedef enum logic [1:0] {
      SER_IDLE,
      SER_HEADER,   // Header beat on link, acks protocol
      SER_DATA
   } ser_state_t;

endpackage
